// File: Bender.yml
package:
  name: branch_predictor

sources:
  - include_dirs:
      - .
    files:
      - bp_isa_pkg.sv
      - bp_pipe_pkg.sv
      - bp_counter_table.sv
      - bp_target_buffer.sv
      - branch_resolver.sv
      - bp_control.sv
      - branch_predictor_top.sv

  - target: simulation
    include_dirs:
      - .
    files:
      - tb_branch_predictor.sv

// File: bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// data and address width
`define BP_XLEN 32

// index bits shared by the counter table and the target buffer
// tables are indexed with pc[BP_INDEX_BITS+1:2]
`define BP_INDEX_BITS 8

// tag bits kept per target buffer entry, taken from the pc bits above the index
`define BP_TAG_BITS 12

// derived sizes
`define BP_ENTRIES (1 << `BP_INDEX_BITS)
`define BP_IDX_LO 2
`define BP_IDX_HI (`BP_INDEX_BITS + 1)
`define BP_TAG_LO (`BP_INDEX_BITS + 2)
`define BP_TAG_HI (`BP_INDEX_BITS + `BP_TAG_BITS + 1)

// byte step to the next sequential instruction
`define BP_INSTR_BYTES 4

`endif

// File: bp_control.sv
`timescale 1ns/1ns
`include "bp_config.svh"

module bp_control
  import bp_isa_pkg::*, bp_pipe_pkg::*;
(
  input  dec_req_t                  dec,
  output pred_t                     pred,
  input  logic [1:0]                ctr_state,
  input  btb_hit_t                  btb,
  output logic [`BP_INDEX_BITS-1:0] ctr_rd_index,
  output logic [`BP_INDEX_BITS-1:0] btb_lk_index,
  output logic [`BP_TAG_BITS-1:0]   btb_lk_tag,
  input  ex_req_t                   ex,
  input  resolve_t                  res,
  output ctr_upd_t                  ctr_upd,
  output btb_upd_t                  btb_upd,
  output redirect_t                 redirect
);

  opcode_e                   dec_op;
  logic                      dec_is_branch;
  logic                      dec_is_jal;
  logic [`BP_INDEX_BITS-1:0] ex_index;
  logic [`BP_TAG_BITS-1:0]   ex_tag;
  logic                      ex_cf;
  logic                      dir_miss;
  logic                      tgt_miss;

  // decode side
  assign dec_op        = dec.instr.btype.opcode;
  assign dec_is_branch = (dec_op == op_branch);
  assign dec_is_jal    = (dec_op == op_jal);

  assign ctr_rd_index = dec.pc[`BP_IDX_HI:`BP_IDX_LO];
  assign btb_lk_index = dec.pc[`BP_IDX_HI:`BP_IDX_LO];
  assign btb_lk_tag   = dec.pc[`BP_TAG_HI:`BP_TAG_LO];

  always_comb begin
    pred.taken  = dec.valid && btb.hit &&
                  (dec_is_jal || (dec_is_branch && ctr_state[1]));  // 10 or 11
    pred.target = btb.target;
  end

  // execute side
  assign ex_index = ex.pc[`BP_IDX_HI:`BP_IDX_LO];
  assign ex_tag   = ex.pc[`BP_TAG_HI:`BP_TAG_LO];
  assign ex_cf    = ex.valid && (res.is_branch || res.is_jal);

  assign dir_miss = (ex.pred.taken != res.taken);
  assign tgt_miss = ex.pred.taken && res.taken && (ex.pred.target != res.target);

  always_comb begin
    ctr_upd.en    = ex.valid && res.is_branch;
    ctr_upd.index = ex_index;
    ctr_upd.taken = res.taken;
  end

  always_comb begin
    btb_upd.en     = ex_cf && res.taken;  // jal or taken branch
    btb_upd.index  = ex_index;
    btb_upd.tag    = ex_tag;
    btb_upd.target = res.target;
  end

  always_comb begin
    redirect.valid = ex_cf && (dir_miss || tgt_miss);
    redirect.pc    = res.taken ? res.target : ex.pc + `BP_INSTR_BYTES;
  end

endmodule

// File: bp_counter_table.sv
`timescale 1ns/1ns
`include "bp_config.svh"

module bp_counter_table
  import bp_pipe_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`BP_INDEX_BITS-1:0] rd_index,
  output logic [1:0]                rd_state,
  input  ctr_upd_t                  upd
);

  logic [1:0] ctr [`BP_ENTRIES];

  // hysteresis transition, msb is the prediction
  function automatic logic [1:0] next_state(input logic [1:0] cur, input logic taken);
    logic [1:0] nxt;
    if (taken) begin
      case (cur)
        2'b00:   nxt = 2'b01;
        default: nxt = 2'b11;  // 01, 10 and 11 all saturate
      endcase
    end else begin
      case (cur)
        2'b11:   nxt = 2'b10;
        default: nxt = 2'b00;
      endcase
    end
    return nxt;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `BP_ENTRIES; i++) begin
        ctr[i] <= 2'b00;
      end
    end else if (upd.en) begin
      ctr[upd.index] <= next_state(ctr[upd.index], upd.taken);
    end
  end

  assign rd_state = ctr[rd_index];  // async read, old value on same-cycle update

endmodule

// File: bp_isa_pkg.sv
package bp_isa_pkg;

  typedef enum logic [6:0] {
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    f3_beq  = 3'b000,
    f3_bne  = 3'b001,
    f3_blt  = 3'b100,
    f3_bge  = 3'b101,
    f3_bltu = 3'b110,
    f3_bgeu = 3'b111
  } funct3_e;

  // conditional branch layout
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    funct3_e    funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_e    opcode;
  } btype_t;

  // jal layout, immediate bits scattered
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } jtype_t;

  // opcode sits at [6:0] in both views
  typedef union packed {
    btype_t btype;
    jtype_t jtype;
  } instr_u;

endpackage

// File: bp_pipe_pkg.sv
`include "bp_config.svh"

package bp_pipe_pkg;

  import bp_isa_pkg::*;

  typedef struct packed {
    logic                taken;
    logic [`BP_XLEN-1:0] target;
  } pred_t;

  typedef struct packed {
    logic                valid;
    logic [`BP_XLEN-1:0] pc;
    instr_u              instr;
  } dec_req_t;

  typedef struct packed {
    logic                valid;
    logic [`BP_XLEN-1:0] pc;
    instr_u              instr;
    logic [`BP_XLEN-1:0] rs1_val;
    logic [`BP_XLEN-1:0] rs2_val;
    pred_t               pred;  // prediction made at decode
  } ex_req_t;

  typedef struct packed {
    logic                is_branch;
    logic                is_jal;
    logic                taken;
    logic [`BP_XLEN-1:0] target;
  } resolve_t;

  typedef struct packed {
    logic                      en;
    logic [`BP_INDEX_BITS-1:0] index;
    logic                      taken;
  } ctr_upd_t;

  typedef struct packed {
    logic                      en;
    logic [`BP_INDEX_BITS-1:0] index;
    logic [`BP_TAG_BITS-1:0]   tag;
    logic [`BP_XLEN-1:0]       target;
  } btb_upd_t;

  typedef struct packed {
    logic                hit;
    logic [`BP_XLEN-1:0] target;
  } btb_hit_t;

  typedef struct packed {
    logic                valid;
    logic [`BP_XLEN-1:0] pc;
  } redirect_t;

endpackage

// File: bp_target_buffer.sv
`timescale 1ns/1ns
`include "bp_config.svh"

module bp_target_buffer
  import bp_pipe_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`BP_INDEX_BITS-1:0] lk_index,
  input  logic [`BP_TAG_BITS-1:0]   lk_tag,
  output btb_hit_t                  lk,
  input  btb_upd_t                  upd
);

  logic [`BP_ENTRIES-1:0] valid;
  logic [`BP_TAG_BITS-1:0] tag_mem [`BP_ENTRIES];
  logic [`BP_XLEN-1:0]     tgt_mem [`BP_ENTRIES];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
    end else if (upd.en) begin
      valid[upd.index] <= 1'b1;
    end
  end

  // aliasing pcs simply overwrite the entry
  always_ff @(posedge clk) begin
    if (upd.en) begin
      tag_mem[upd.index] <= upd.tag;
      tgt_mem[upd.index] <= upd.target;
    end
  end

  always_comb begin
    lk.hit    = valid[lk_index] && (tag_mem[lk_index] == lk_tag);
    lk.target = tgt_mem[lk_index];
  end

endmodule

// File: branch_predictor_top.sv
`timescale 1ns/1ns
`include "bp_config.svh"

module branch_predictor_top
  import bp_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  dec_req_t  dec,
  output pred_t     pred,
  input  ex_req_t   ex,
  output redirect_t redirect
);

  logic [1:0]                ctr_state;
  logic [`BP_INDEX_BITS-1:0] ctr_rd_index;
  logic [`BP_INDEX_BITS-1:0] btb_lk_index;
  logic [`BP_TAG_BITS-1:0]   btb_lk_tag;
  btb_hit_t                  btb;
  resolve_t                  res;
  ctr_upd_t                  ctr_upd;
  btb_upd_t                  btb_upd;

  bp_control u_control (
    .dec          (dec),
    .pred         (pred),
    .ctr_state    (ctr_state),
    .btb          (btb),
    .ctr_rd_index (ctr_rd_index),
    .btb_lk_index (btb_lk_index),
    .btb_lk_tag   (btb_lk_tag),
    .ex           (ex),
    .res          (res),
    .ctr_upd      (ctr_upd),
    .btb_upd      (btb_upd),
    .redirect     (redirect)
  );

  bp_counter_table u_counter_table (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_index (ctr_rd_index),
    .rd_state (ctr_state),
    .upd      (ctr_upd)
  );

  bp_target_buffer u_target_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .lk_index (btb_lk_index),
    .lk_tag   (btb_lk_tag),
    .lk       (btb),
    .upd      (btb_upd)
  );

  branch_resolver u_resolver (
    .ex  (ex),
    .res (res)
  );

endmodule

// File: branch_resolver.sv
`timescale 1ns/1ns
`include "bp_config.svh"

module branch_resolver
  import bp_isa_pkg::*, bp_pipe_pkg::*;
(
  input  ex_req_t  ex,
  output resolve_t res
);

  btype_t              b;
  jtype_t              j;
  logic [`BP_XLEN-1:0] imm_b;
  logic [`BP_XLEN-1:0] imm_j;
  logic                is_branch;
  logic                is_jal;
  logic                eq;
  logic                lt_s;
  logic                lt_u;
  logic                cond;

  assign b = ex.instr.btype;
  assign j = ex.instr.jtype;

  assign is_branch = (b.opcode == op_branch);
  assign is_jal    = (j.opcode == op_jal);

  // sign-extended offsets with bit 0 zero
  assign imm_b = {{(`BP_XLEN-13){b.imm12}}, b.imm12, b.imm11, b.imm10_5, b.imm4_1, 1'b0};
  assign imm_j = {{(`BP_XLEN-21){j.imm20}}, j.imm20, j.imm19_12, j.imm11, j.imm10_1, 1'b0};

  assign eq   = (ex.rs1_val == ex.rs2_val);
  assign lt_s = ($signed(ex.rs1_val) < $signed(ex.rs2_val));
  assign lt_u = (ex.rs1_val < ex.rs2_val);

  always_comb begin
    case (b.funct3)
      f3_beq:  cond = eq;
      f3_bne:  cond = !eq;
      f3_blt:  cond = lt_s;
      f3_bge:  cond = !lt_s;
      f3_bltu: cond = lt_u;
      f3_bgeu: cond = !lt_u;
      default: cond = 1'b0;  // reserved funct3 never taken
    endcase
  end

  always_comb begin
    res.is_branch = is_branch;
    res.is_jal    = is_jal;
    res.taken     = is_jal || (is_branch && cond);
    res.target    = ex.pc + (is_jal ? imm_j : imm_b);
  end

endmodule

// File: sim.f
+incdir+.
bp_isa_pkg.sv
bp_pipe_pkg.sv
bp_counter_table.sv
bp_target_buffer.sv
branch_resolver.sv
bp_control.sv
branch_predictor_top.sv
tb_branch_predictor.sv

// File: tb_branch_predictor.sv
`timescale 1ns/1ns
`include "bp_config.svh"

module tb_branch_predictor
  import bp_isa_pkg::*, bp_pipe_pkg::*;
;

  localparam int CYCLE_LIMIT = 3000;  // ~200 directed + 2000 random plus margin

  logic      clk;
  logic      rst_n;
  dec_req_t  dec;
  pred_t     pred;
  ex_req_t   ex;
  redirect_t redirect;

  pred_t     exp_pred;
  redirect_t exp_redir;
  ex_req_t   held;  // decode request waiting for execute
  logic      flush;
  logic [31:0] rng;
  string     test_name;
  int        cycles;

  // model tables
  logic [1:0]  ctr_m   [`BP_ENTRIES];
  logic        btb_v   [`BP_ENTRIES];
  logic [11:0] btb_tag [`BP_ENTRIES];
  logic [31:0] btb_tgt [`BP_ENTRIES];

  branch_predictor_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .dec      (dec),
    .pred     (pred),
    .ex       (ex),
    .redirect (redirect)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [31:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
  endfunction

  // actual direction and target from the ISA rules
  function automatic pred_t outcome(input logic [31:0] pc, input logic [31:0] w,
                                    input logic [31:0] a, input logic [31:0] b);
    pred_t       o;
    logic [31:0] imm;
    logic        c;
    o = '0;
    if (w[6:0] == 7'b1101111) begin
      imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      o.taken  = 1'b1;
      o.target = pc + imm;
    end else if (w[6:0] == 7'b1100011) begin
      imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      case (w[14:12])
        3'b000:  c = (a == b);
        3'b001:  c = (a != b);
        3'b100:  c = ($signed(a) < $signed(b));
        3'b101:  c = ($signed(a) >= $signed(b));
        3'b110:  c = (a < b);
        3'b111:  c = (a >= b);
        default: c = 1'b0;
      endcase
      o.taken  = c;
      o.target = pc + imm;
    end
    return o;
  endfunction

  function automatic pred_t predict(input dec_req_t d);
    pred_t       p;
    logic [31:0] w;
    logic [7:0]  idx;
    logic        hit;
    w   = d.instr;
    idx = d.pc[`BP_IDX_HI:`BP_IDX_LO];
    hit = btb_v[idx] && (btb_tag[idx] == d.pc[`BP_TAG_HI:`BP_TAG_LO]);
    p.taken  = d.valid && hit &&
               (w[6:0] == 7'b1101111 || (w[6:0] == 7'b1100011 && ctr_m[idx] >= 2'b10));
    p.target = btb_tgt[idx];
    return p;
  endfunction

  function automatic redirect_t resolve(input ex_req_t e);
    redirect_t   r;
    pred_t       act;
    logic [31:0] w;
    logic        cf;
    w   = e.instr;
    act = outcome(e.pc, w, e.rs1_val, e.rs2_val);
    cf  = e.valid && (w[6:0] == 7'b1100011 || w[6:0] == 7'b1101111);
    r.valid = cf && ((e.pred.taken != act.taken) ||
                     (e.pred.taken && act.taken && e.pred.target != act.target));
    r.pc    = act.taken ? act.target : e.pc + 32'd4;
    return r;
  endfunction

  function automatic logic [1:0] next_ctr(input logic [1:0] s, input logic t);
    case ({t, s})
      3'b100:  return 2'b01;
      3'b101:  return 2'b11;
      3'b110:  return 2'b11;
      3'b111:  return 2'b11;
      3'b011:  return 2'b10;
      default: return 2'b00;
    endcase
  endfunction

  task automatic apply_update(input ex_req_t e);
    pred_t       act;
    logic [31:0] w;
    logic [7:0]  idx;
    w   = e.instr;
    act = outcome(e.pc, w, e.rs1_val, e.rs2_val);
    idx = e.pc[`BP_IDX_HI:`BP_IDX_LO];
    if (e.valid && w[6:0] == 7'b1100011)
      ctr_m[idx] = next_ctr(ctr_m[idx], act.taken);
    if (e.valid && (w[6:0] == 7'b1100011 || w[6:0] == 7'b1101111) && act.taken) begin
      btb_v[idx]   = 1'b1;
      btb_tag[idx] = e.pc[`BP_TAG_HI:`BP_TAG_LO];
      btb_tgt[idx] = act.target;
    end
  endtask

  // decode of the new word and execute of the previous one
  task automatic step(input logic v, input logic [31:0] pc, input logic [31:0] w,
                      input logic [31:0] a, input logic [31:0] b);
    ex_req_t nxt;
    @(negedge clk);
    nxt = held;
    if (flush) nxt.valid = 1'b0;  // decode squashed by last redirect
    ex        = nxt;
    dec.valid = v;
    dec.pc    = pc;
    dec.instr = w;
    exp_pred  = predict(dec);
    exp_redir = resolve(ex);
    held.valid   = v;
    held.pc      = pc;
    held.instr   = w;
    held.rs1_val = a;
    held.rs2_val = b;
    held.pred    = exp_pred;
    flush        = exp_redir.valid;
  endtask

  task automatic issue(input logic [31:0] pc, input logic [31:0] w,
                       input logic [31:0] a, input logic [31:0] b);
    step(1'b1, pc, w, a, b);
    step(1'b0, 32'd0, 32'd0, 32'd0, 32'd0);
  endtask

  function automatic logic [2:0] funct3_at(input int k);
    case (k)
      0:       return f3_beq;
      1:       return f3_bne;
      2:       return f3_blt;
      3:       return f3_bge;
      4:       return f3_bltu;
      default: return f3_bgeu;
    endcase
  endfunction

  function automatic logic [31:0] pool_pc(input logic [2:0] k);
    case (k)
      3'd0:    return 32'h0000_1000;
      3'd1:    return 32'h0000_1004;
      3'd2:    return 32'h0000_1400;  // aliases 0x1000
      3'd3:    return 32'h0000_2008;
      3'd4:    return 32'h0004_2008;  // aliases 0x2008
      3'd5:    return 32'h0000_3ffc;
      3'd6:    return 32'h0000_1800;
      default: return 32'h0000_2100;
    endcase
  endfunction

  function automatic logic [31:0] offset_at(input logic [1:0] k);
    case (k)
      2'd0:    return 32'h0000_0040;
      2'd1:    return 32'hffff_ffe0;
      2'd2:    return 32'h0000_0100;
      default: return 32'hffff_f800;
    endcase
  endfunction

  always @(posedge clk) begin
    if (rst_n) begin
      assert (pred.taken === exp_pred.taken &&
              (!exp_pred.taken || pred.target === exp_pred.target))
      else begin
        $display("ERR %s pred expected taken=%0b target=%h actual taken=%0b target=%h",
                 test_name, exp_pred.taken, exp_pred.target, pred.taken, pred.target);
        $display("*** TEST FAILED ***");
        $fatal(1, "prediction mismatch");
      end
      assert (redirect.valid === exp_redir.valid &&
              (!exp_redir.valid || redirect.pc === exp_redir.pc))
      else begin
        $display("ERR %s redirect expected valid=%0b pc=%h actual valid=%0b pc=%h",
                 test_name, exp_redir.valid, exp_redir.pc, redirect.valid, redirect.pc);
        $display("*** TEST FAILED ***");
        $fatal(1, "redirect mismatch");
      end
      apply_update(ex);  // model tables change after the checks
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    logic [31:0] a;
    clk = 1'b0;
    rst_n = 1'b0;
    dec = '0;
    ex = '0;
    held = '0;
    exp_pred = '0;
    exp_redir = '0;
    flush = 1'b0;
    cycles = 0;
    rng = 32'hbc6bdb06;
    test_name = "reset";
    for (int i = 0; i < `BP_ENTRIES; i++) begin
      ctr_m[i] = 2'b00;
      btb_v[i] = 1'b0;
      btb_tag[i] = '0;
      btb_tgt[i] = '0;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    test_name = "cold";
    for (int k = 0; k < 4; k++) begin
      issue(32'h0000_0100 + k * 64, enc_branch(f3_bne, 32'h40), 32'd7, 32'd7);
      issue(32'h0000_0600 + k * 64, enc_jal(32'h200), 32'd0, 32'd0);
    end

    test_name = "hysteresis";
    issue(32'h0000_2000, enc_branch(f3_beq, 32'h40), 32'd3, 32'd3);
    issue(32'h0000_2000, enc_branch(f3_beq, 32'h40), 32'd3, 32'd3);
    issue(32'h0000_2000, enc_branch(f3_beq, 32'h40), 32'd3, 32'd4);
    issue(32'h0000_2000, enc_branch(f3_beq, 32'h40), 32'd3, 32'd3);
    issue(32'h0000_2000, enc_branch(f3_beq, 32'h40), 32'd3, 32'd4);
    issue(32'h0000_2000, enc_branch(f3_beq, 32'h40), 32'd3, 32'd4);

    test_name = "target_buffer";
    repeat (3) issue(32'h0000_3000, enc_branch(f3_bne, 32'h80), 32'd1, 32'd2);
    issue(32'h0000_3400, enc_branch(f3_bne, 32'hffff_ffc0), 32'd1, 32'd2);
    issue(32'h0000_3000, enc_branch(f3_bne, 32'h80), 32'd5, 32'd5);
    issue(32'h0000_3400, enc_branch(f3_bne, 32'hffff_ffc0), 32'd1, 32'd2);

    test_name = "resolution";
    for (int f = 0; f < 6; f++) begin
      issue(32'h0000_4000 + f * 32, enc_branch(funct3_at(f), 32'h100), 32'hffff_ffff, 32'd1);
      issue(32'h0000_4004 + f * 32, enc_branch(funct3_at(f), 32'hffff_ffc0), 32'd1, 32'hffff_ffff);
      issue(32'h0000_4008 + f * 32, enc_branch(funct3_at(f), 32'h100), 32'd5, 32'd5);
      issue(32'h0000_400c + f * 32, enc_branch(funct3_at(f), 32'hffff_ffc0),
            32'h8000_0000, 32'h7fff_ffff);
    end

    test_name = "jal";
    issue(32'h0000_5000, enc_jal(32'h800), 32'd0, 32'd0);
    issue(32'h0000_5000, enc_jal(32'h800), 32'd0, 32'd0);
    issue(32'h0000_5000, enc_jal(32'h1000), 32'd0, 32'd0);  // stale target in buffer
    issue(32'h0000_5000, enc_jal(32'h1000), 32'd0, 32'd0);

    test_name = "random";
    for (int n = 0; n < 2000; n++) begin
      rng = xorshift(rng);
      r = rng;
      if (r[0])
        w = enc_jal(r[3] ? 32'h1000 : offset_at(r[5:4]));
      else
        w = enc_branch(funct3_at(r[10:8] % 6), offset_at(r[5:4]));
      rng = xorshift(rng);
      a = rng;
      rng = xorshift(rng);
      step(r[14:12] != 3'd0, pool_pc(r[18:16]), w, a, r[20] ? a : rng);
    end

    test_name = "drain";
    step(1'b0, 32'd0, 32'd0, 32'd0, 32'd0);
    step(1'b0, 32'd0, 32'd0, 32'd0, 32'd0);
    @(negedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
